// File: design/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath width
`define DATA_W 32

// Instruction and memory word
`define INSTR_W 16

// Word address into the 4K memory
`define ADDR_W 12

`define NREGS 8

// First fetch after reset
`define RESET_IP 12'h008

// Register tested by every jump
`define BRANCH_REG 3'd5

`endif

// File: design/isa_pkg.sv
`default_nettype none
`include "core_macros.svh"

package isa_pkg;

    typedef logic [2:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_MISC  = 4'b0000,
        OP_ARITH = 4'b0001,  // ADD SUB MUL SAR
        OP_LOGIC = 4'b0010,  // AND OR XOR ROL
        OP_MEM   = 4'b0011,  // STRAML STRAMH
        OP_MOVLL = 4'b0100,
        OP_MOVLH = 4'b0101,
        OP_MOVHL = 4'b0110,
        OP_MOVHH = 4'b0111
    } opcode_e;

    // Group 0000 function from src1 and func together
    typedef enum logic [4:0] {
        FN_END    = 5'b00000,
        FN_NOP    = 5'b00011,
        FN_OUT    = 5'b01100,
        FN_MOV    = 5'b10000,
        FN_NOT    = 5'b10001,
        FN_NEG    = 5'b10010,
        FN_LDRAML = 5'b11000,
        FN_LDRAMH = 5'b11001
    } misc_func_e;

    typedef enum logic [2:0] {
        CND_JMP  = 3'b001,
        CND_JEZ  = 3'b010,
        CND_JNZ  = 3'b011,
        CND_JAZ  = 3'b100,
        CND_JBZ  = 3'b101,
        CND_JAEZ = 3'b110,
        CND_JBEZ = 3'b111
    } cond_e;

    typedef struct packed {
        logic       branch;  // Always 0 in this view
        opcode_e    opcode;
        reg_idx_t   dst;
        reg_idx_t   src0;
        reg_idx_t   src1;
        logic [1:0] func;
    } reg_fmt_t;

    typedef struct packed {
        logic               branch;
        cond_e              cond;
        logic [`ADDR_W-1:0] target;
    } br_fmt_t;

    // Bit 15 picks the view
    typedef union packed {
        reg_fmt_t r;
        br_fmt_t  b;
    } instr_u;

endpackage

`default_nettype wire

// File: design/core_pkg.sv
`default_nettype none
`include "core_macros.svh"

package core_pkg;

    typedef struct packed {
        logic [`ADDR_W-1:0]  addr;
        logic [`INSTR_W-1:0] wdata;
        logic                we;
    } mem_req_t;

    typedef struct packed {
        logic [`INSTR_W-1:0] rdata;
    } mem_rsp_t;

    typedef enum logic [3:0] {
        ALU_PASS, ALU_NOT, ALU_NEG,
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_SAR,
        ALU_AND, ALU_OR, ALU_XOR, ALU_ROL
    } alu_op_e;

    typedef struct packed {
        alu_op_e           alu_op;
        isa_pkg::reg_idx_t ra0;
        isa_pkg::reg_idx_t ra1;
        isa_pkg::reg_idx_t wa;
        logic              we_h;
        logic              we_l;
        logic              imm;    // Byte insert into rd0
        logic [1:0]        lane;
        logic              load;
        logic              store;
        logic              out;
        logic              jump;
        logic              halt;
        logic              hsel;   // High half for stores
    } dec_t;

    typedef enum logic [2:0] {
        ST_FETCH, ST_WAIT_INSTR, ST_EXEC, ST_WAIT_LOAD,
        ST_WAIT_STORE, ST_WAIT_OUT, ST_HALT
    } seq_state_e;

endpackage

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module alu
    import core_pkg::*;
(
    input  wire alu_op_e        op,
    input  wire [`DATA_W-1:0]   a,
    input  wire [`DATA_W-1:0]   b,
    output logic [`DATA_W-1:0]  result
);

    logic [4:0]           sh;
    logic [2*`DATA_W-1:0] rot;

    assign sh  = b[4:0];
    assign rot = {a, a} << sh;  // Upper word is the rotate

    always_comb begin
        case (op)
            ALU_PASS: begin
                result = a;
            end
            ALU_NOT: begin
                result = ~a;
            end
            ALU_NEG: begin
                result = -a;
            end
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_MUL: begin
                result = a * b;  // Low word only
            end
            ALU_SAR: begin
                result = $signed(a) >>> sh;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_ROL: begin
                result = rot[2*`DATA_W-1:`DATA_W];
            end
            default: begin
                result = a;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module reg_file
    import isa_pkg::*;
(
    input  wire                 CLK,
    input  wire                 rst_n,
    input  wire reg_idx_t       ra0,
    input  wire reg_idx_t       ra1,
    input  wire reg_idx_t       wa,
    input  wire [`DATA_W-1:0]   wr_data,
    input  wire                 wr_en,
    input  wire                 we_h,
    input  wire                 we_l,
    output logic [`DATA_W-1:0]  rd0,
    output logic [`DATA_W-1:0]  rd1
);

    localparam int HALF = `DATA_W / 2;

    logic [`DATA_W-1:0] regs [`NREGS];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            if (we_h) begin
                regs[wa][`DATA_W-1:HALF] <= wr_data[`DATA_W-1:HALF];
            end
            if (we_l) begin
                regs[wa][HALF-1:0] <= wr_data[HALF-1:0];
            end
        end
    end

    assign rd0 = regs[ra0];
    assign rd1 = regs[ra1];

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module instr_decoder
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire instr_u instr,
    output dec_t        dec
);

    misc_func_e fn;

    assign fn = misc_func_e'({instr.r.src1, instr.r.func});

    always_comb begin
        dec        = '0;  // All flags clear is a NOP
        dec.alu_op = ALU_PASS;
        dec.ra0    = instr.r.src0;
        dec.ra1    = instr.r.src1;
        dec.wa     = instr.r.dst;
        dec.lane   = instr.r.opcode[1:0];
        dec.hsel   = instr.r.func[0];
        if (instr.b.branch) begin
            dec.ra0  = `BRANCH_REG;
            dec.jump = |instr.b.cond;  // 000 is the dropped CALL
        end else begin
            case (instr.r.opcode)
                OP_MISC: begin
                    case (fn)
                        FN_END:    dec.halt = 1'b1;
                        FN_OUT:    dec.out  = 1'b1;
                        FN_MOV:    {dec.we_h, dec.we_l} = 2'b11;
                        FN_NOT:    {dec.alu_op, dec.we_h, dec.we_l} = {ALU_NOT, 2'b11};
                        FN_NEG:    {dec.alu_op, dec.we_h, dec.we_l} = {ALU_NEG, 2'b11};
                        FN_LDRAML: {dec.load, dec.we_l} = 2'b11;
                        FN_LDRAMH: {dec.load, dec.we_h} = 2'b11;
                        default:   dec.halt = 1'b0;
                    endcase
                end
                OP_ARITH: begin
                    {dec.we_h, dec.we_l} = 2'b11;
                    case (instr.r.func)
                        2'd0:    dec.alu_op = ALU_ADD;
                        2'd1:    dec.alu_op = ALU_SUB;
                        2'd2:    dec.alu_op = ALU_MUL;
                        default: dec.alu_op = ALU_SAR;
                    endcase
                end
                OP_LOGIC: begin
                    {dec.we_h, dec.we_l} = 2'b11;
                    case (instr.r.func)
                        2'd0:    dec.alu_op = ALU_AND;
                        2'd1:    dec.alu_op = ALU_OR;
                        2'd2:    dec.alu_op = ALU_XOR;
                        default: dec.alu_op = ALU_ROL;
                    endcase
                end
                OP_MEM: dec.store = !instr.r.func[1];  // STSPRD and LDSPRD dropped
                OP_MOVLL, OP_MOVLH, OP_MOVHL, OP_MOVHH: begin
                    dec.imm              = 1'b1;
                    dec.ra0              = instr.r.dst;
                    {dec.we_h, dec.we_l} = 2'b11;
                end
                default: dec.imm = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/core_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module core_sequencer
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire                 CLK,
    input  wire                 rst_n,
    input  wire dec_t           dec,
    input  wire [`DATA_W-1:0]   rd0,
    input  wire [`DATA_W-1:0]   rd1,
    input  wire [`DATA_W-1:0]   alu_result,
    input  wire                 mem_req_ready,
    input  wire mem_rsp_t       mem_rsp,
    input  wire                 mem_rsp_valid,
    input  wire                 out_ready,
    output instr_u              instr,
    output logic [`DATA_W-1:0]  wr_data,
    output logic                wr_en,
    output mem_req_t            mem_req,
    output logic                mem_req_valid,
    output logic [`DATA_W-1:0]  out_data,
    output logic                out_valid,
    output logic                halted
);

    seq_state_e          state;
    logic [`ADDR_W-1:0]  ip;
    logic [`ADDR_W-1:0]  next_ip;
    logic [`INSTR_W-1:0] ld_data;
    logic                ld_wb;     // Load write-back pending
    logic                take;
    logic                is_zero;
    logic                is_neg;
    logic                req_fire;
    logic                issue;     // New request next cycle
    mem_req_t            issue_req;
    logic [`DATA_W-1:0]  ins_data;

    assign req_fire = mem_req_valid && mem_req_ready;
    assign halted   = (state == ST_HALT);
    assign is_zero  = (rd0 == '0);
    assign is_neg   = rd0[`DATA_W-1];
    assign next_ip  = (dec.jump && take) ? instr.b.target : ip + 1'b1;
    assign wr_en    = ld_wb || (state == ST_EXEC && !dec.load && (dec.we_h || dec.we_l));

    always_comb begin
        case (instr.b.cond)
            CND_JMP:  take = 1'b1;
            CND_JEZ:  take = is_zero;
            CND_JNZ:  take = !is_zero;
            CND_JAZ:  take = !is_neg && !is_zero;
            CND_JBZ:  take = is_neg;
            CND_JAEZ: take = !is_neg;
            CND_JBEZ: take = is_neg || is_zero;
            default:  take = 1'b0;
        endcase
    end

    always_comb begin
        ins_data                      = alu_result;
        ins_data[8*dec.lane +: 8]     = instr[7:0];
        if (ld_wb) begin
            wr_data = {ld_data, ld_data};  // Half picked by we_h/we_l
        end else if (dec.imm) begin
            wr_data = ins_data;
        end else begin
            wr_data = alu_result;
        end
    end

    always_comb begin
        issue     = 1'b0;
        issue_req = '{addr: ip, wdata: '0, we: 1'b0};
        case (state)
            ST_FETCH:      issue = !mem_req_valid;  // Only right after reset
            ST_EXEC: begin
                if (dec.load) begin
                    issue          = 1'b1;
                    issue_req.addr = rd0[`ADDR_W-1:0];
                end else if (dec.store) begin
                    issue           = 1'b1;
                    issue_req.addr  = rd1[`ADDR_W-1:0];
                    issue_req.wdata = dec.hsel ? rd0[`DATA_W-1:`INSTR_W] : rd0[`INSTR_W-1:0];
                    issue_req.we    = 1'b1;
                end else if (!dec.halt && !dec.out) begin
                    issue          = 1'b1;
                    issue_req.addr = next_ip;
                end
            end
            ST_WAIT_LOAD:  issue = mem_rsp_valid;
            ST_WAIT_STORE: issue = req_fire;
            ST_WAIT_OUT:   issue = out_ready;
            default:       issue = 1'b0;
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_FETCH;
            ip            <= `RESET_IP;
            mem_req_valid <= 1'b0;
            out_valid     <= 1'b0;
            ld_wb         <= 1'b0;
        end else begin
            ld_wb <= 1'b0;
            if (issue) begin
                mem_req_valid <= 1'b1;
            end else if (req_fire) begin
                mem_req_valid <= 1'b0;
            end
            case (state)
                ST_FETCH: begin
                    if (req_fire) begin
                        state <= ST_WAIT_INSTR;
                    end
                end
                ST_WAIT_INSTR: begin
                    if (mem_rsp_valid) begin
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    ip <= next_ip;
                    if (dec.halt) begin
                        state <= ST_HALT;
                    end else if (dec.load) begin
                        state <= ST_WAIT_LOAD;
                    end else if (dec.store) begin
                        state <= ST_WAIT_STORE;
                    end else if (dec.out) begin
                        state     <= ST_WAIT_OUT;
                        out_valid <= 1'b1;
                    end else begin
                        state <= ST_FETCH;
                    end
                end
                ST_WAIT_LOAD: begin
                    if (mem_rsp_valid) begin
                        ld_wb <= 1'b1;
                        state <= ST_FETCH;
                    end
                end
                ST_WAIT_STORE: begin
                    if (req_fire) begin
                        state <= ST_FETCH;
                    end
                end
                ST_WAIT_OUT: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        state     <= ST_FETCH;
                    end
                end
                default: state <= ST_HALT;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (issue) begin
            mem_req <= issue_req;
        end
        if (state == ST_WAIT_INSTR && mem_rsp_valid) begin
            instr <= mem_rsp.rdata;
        end
        if (state == ST_WAIT_LOAD && mem_rsp_valid) begin
            ld_data <= mem_rsp.rdata;
        end
        if (state == ST_EXEC && dec.out) begin
            out_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

// File: design/core_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module core_top
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire                 CLK,
    input  wire                 rst_n,
    input  wire                 mem_req_ready,
    input  wire mem_rsp_t       mem_rsp,
    input  wire                 mem_rsp_valid,
    input  wire                 out_ready,
    output mem_req_t            mem_req,
    output logic                mem_req_valid,
    output logic [`DATA_W-1:0]  out_data,
    output logic                out_valid,
    output logic                halted
);

    instr_u             instr;
    dec_t               dec;
    logic [`DATA_W-1:0] rd0;
    logic [`DATA_W-1:0] rd1;
    logic [`DATA_W-1:0] alu_result;
    logic [`DATA_W-1:0] wr_data;
    logic               wr_en;

    core_sequencer u_core_sequencer (
        .CLK(CLK), .rst_n(rst_n), .dec(dec), .rd0(rd0), .rd1(rd1),
        .alu_result(alu_result), .mem_req_ready(mem_req_ready), .mem_rsp(mem_rsp),
        .mem_rsp_valid(mem_rsp_valid), .out_ready(out_ready), .instr(instr),
        .wr_data(wr_data), .wr_en(wr_en), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
        .out_data(out_data), .out_valid(out_valid), .halted(halted)
    );

    instr_decoder u_instr_decoder (.instr(instr), .dec(dec));

    reg_file u_reg_file (
        .CLK(CLK), .rst_n(rst_n), .ra0(dec.ra0), .ra1(dec.ra1), .wa(dec.wa),
        .wr_data(wr_data), .wr_en(wr_en), .we_h(dec.we_h), .we_l(dec.we_l),
        .rd0(rd0), .rd1(rd1)
    );

    alu u_alu (.op(dec.alu_op), .a(rd0), .b(rd1), .result(alu_result));

endmodule

`default_nettype wire

// File: tests/core_tb_sva.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module core_tb_sva
    import core_pkg::*;
(
    input wire                CLK,
    input wire                rst_n,
    input wire mem_req_t      mem_req,
    input wire                mem_req_valid,
    input wire                mem_req_ready,
    input wire [`DATA_W-1:0]  out_data,
    input wire                out_valid,
    input wire                out_ready,
    input wire                halted
);

    req_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req dropped or changed while stalled");

    out_hold: assert property (@(posedge CLK) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_data dropped or changed while stalled");

    reset_quiet: assert property (@(posedge CLK)
        !rst_n |-> !mem_req_valid && !out_valid)
        else $error("valid raised during reset");

    // Halt is final
    halt_quiet: assert property (@(posedge CLK) disable iff (!rst_n)
        halted |-> !mem_req_valid && !out_valid ##1 halted)
        else $error("activity after halt");

endmodule

bind core_top core_tb_sva u_core_tb_sva (
    .CLK(CLK), .rst_n(rst_n), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
    .mem_req_ready(mem_req_ready), .out_data(out_data), .out_valid(out_valid),
    .out_ready(out_ready), .halted(halted)
);

`default_nettype wire

// File: tests/core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_macros.svh"

module core_tb
    import isa_pkg::*;
    import core_pkg::*;
();

    logic                CLK;
    logic                rst_n;
    logic                mem_req_ready;
    mem_rsp_t            mem_rsp;
    logic                mem_rsp_valid;
    logic                out_ready;
    mem_req_t            mem_req;
    logic                mem_req_valid;
    logic [`DATA_W-1:0]  out_data;
    logic                out_valid;
    logic                halted;

    logic [`INSTR_W-1:0] mem     [4096];
    logic [`INSTR_W-1:0] ref_mem [4096];  // Image for the ISA model
    logic [`DATA_W-1:0]  exp_q   [$];
    logic [`INSTR_W-1:0] rsp_data;
    int                  rsp_cnt;         // Cycles until the read response
    int                  errors;
    integer              seed;
    logic [`ADDR_W-1:0]  pc_asm;

    always #50 CLK = ~CLK;

    core_top u_core_top (
        .CLK(CLK), .rst_n(rst_n), .mem_req_ready(mem_req_ready), .mem_rsp(mem_rsp),
        .mem_rsp_valid(mem_rsp_valid), .out_ready(out_ready), .mem_req(mem_req),
        .mem_req_valid(mem_req_valid), .out_data(out_data), .out_valid(out_valid),
        .halted(halted)
    );

    task automatic check_val(input string name, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [15:0] reg_op(logic [3:0] op, logic [2:0] d, logic [2:0] a,
                                           logic [2:0] b, logic [1:0] f);
        return {1'b0, op, d, a, b, f};
    endfunction

    function automatic logic [15:0] misc_op(logic [4:0] fn, logic [2:0] d, logic [2:0] a);
        return {1'b0, 4'b0000, d, a, fn};
    endfunction

    function automatic logic [15:0] imm_op(logic [1:0] lane, logic [2:0] d, logic [7:0] v);
        return {1'b0, 2'b01, lane, d, v};
    endfunction

    function automatic logic [15:0] jump_op(logic [2:0] c, logic [11:0] t);
        return {1'b1, c, t};
    endfunction

    task automatic emit(logic [15:0] w);
        mem[pc_asm] = w;
        pc_asm++;
    endtask

    task automatic build_program();
        logic [`ADDR_W-1:0] loop_top;
        pc_asm = `RESET_IP;
        emit(imm_op(2'd1, 3'd1, 8'h01));       // r1 points at random data
        emit(misc_op(FN_LDRAML, 3'd2, 3'd1));
        emit(imm_op(2'd0, 3'd1, 8'h01));
        emit(misc_op(FN_LDRAMH, 3'd2, 3'd1));
        emit(imm_op(2'd0, 3'd1, 8'h02));
        emit(misc_op(FN_LDRAML, 3'd3, 3'd1));
        emit(imm_op(2'd0, 3'd1, 8'h03));
        emit(misc_op(FN_LDRAMH, 3'd3, 3'd1));
        for (int f = 0; f < 4; f++) begin
            emit(reg_op(OP_ARITH, 3'd4, 3'd2, 3'd3, f[1:0]));
            emit(misc_op(FN_OUT, 3'd0, 3'd4));
            emit(reg_op(OP_LOGIC, 3'd4, 3'd2, 3'd3, f[1:0]));
            emit(misc_op(FN_OUT, 3'd0, 3'd4));
        end
        emit(misc_op(FN_NOT, 3'd4, 3'd2));
        emit(misc_op(FN_OUT, 3'd0, 3'd4));
        emit(misc_op(FN_NEG, 3'd4, 3'd2));
        emit(misc_op(FN_OUT, 3'd0, 3'd4));
        emit(misc_op(FN_MOV, 3'd4, 3'd3));
        emit(misc_op(FN_OUT, 3'd0, 3'd4));
        emit(misc_op(FN_MOV, 3'd6, 3'd2));
        emit(imm_op(2'd1, 3'd6, 8'ha5));       // Only byte 1 changes
        emit(misc_op(FN_OUT, 3'd0, 3'd6));
        for (int l = 0; l < 4; l++) begin
            emit(imm_op(l[1:0], 3'd6, 8'h78 - 8'h22 * l[7:0]));
        end
        emit(misc_op(FN_OUT, 3'd0, 3'd6));
        emit(imm_op(2'd0, 3'd5, 8'h03));
        emit(imm_op(2'd0, 3'd7, 8'h01));
        loop_top = pc_asm;
        emit(misc_op(FN_OUT, 3'd0, 3'd5));
        emit(reg_op(OP_ARITH, 3'd5, 3'd5, 3'd7, 2'd1));
        emit(jump_op(CND_JNZ, loop_top));
        for (int v = 0; v < 3; v++) begin
            if (v == 0) begin
                emit(reg_op(OP_ARITH, 3'd5, 3'd5, 3'd5, 2'd1));
            end else if (v == 1) begin
                emit(imm_op(2'd0, 3'd5, 8'h40));
            end else begin
                emit(misc_op(FN_NEG, 3'd5, 3'd5));
            end
            for (int c = 0; c < 8; c++) begin
                emit(jump_op(c[2:0], pc_asm + 2));  // Taken skips the OUT
                emit(misc_op(FN_OUT, 3'd0, 3'd5));
            end
        end
        emit(imm_op(2'd0, 3'd1, 8'h00));
        emit(imm_op(2'd1, 3'd1, 8'h02));       // r1 = 0x200
        for (int k = 0; k < 4; k++) begin
            emit(imm_op(2'd0, 3'd1, k[7:0]));
            emit(reg_op(OP_MEM, 3'd0, 3'd2 + k[2:1], 3'd1, {1'b0, k[0]}));
        end
        for (int k = 0; k < 4; k++) begin
            emit(imm_op(2'd0, 3'd1, k[7:0]));
            emit(misc_op(k[0] ? FN_LDRAMH : FN_LDRAML, 3'd0, 3'd1));
            if (k[0]) begin
                emit(misc_op(FN_OUT, 3'd0, 3'd0));
            end
        end
        emit(misc_op(FN_NOP, 3'd0, 3'd0));
        emit(misc_op(FN_END, 3'd0, 3'd0));
    endtask

    function automatic void ref_exec();
        logic [`DATA_W-1:0]  r [`NREGS];
        logic [`DATA_W-1:0]  a;
        logic [`DATA_W-1:0]  b;
        logic [`INSTR_W-1:0] w;
        logic [`ADDR_W-1:0]  pc;
        logic [2:0]          d;
        logic                z;
        logic                n;
        logic                take;
        int                  steps;
        for (int i = 0; i < `NREGS; i++) begin
            r[i] = '0;
        end
        pc = `RESET_IP;
        for (steps = 0; steps < 10000; steps++) begin
            w  = ref_mem[pc];
            pc = pc + 1'b1;
            d  = w[10:8];
            a  = r[w[7:5]];
            b  = r[w[4:2]];
            z  = (r[`BRANCH_REG] == '0);
            n  = r[`BRANCH_REG][`DATA_W-1];
            if (w[15]) begin
                case (w[14:12])
                    3'd1: take = 1'b1;
                    3'd2: take = z;
                    3'd3: take = !z;
                    3'd4: take = !z && !n;
                    3'd5: take = n;
                    3'd6: take = !n;
                    3'd7: take = z || n;
                    default: take = 1'b0;  // Old CALL slot
                endcase
                if (take) begin
                    pc = w[11:0];
                end
            end else if (w[14:11] == 4'b0000) begin
                case (w[4:0])
                    5'b00000: return;
                    5'b01100: exp_q.push_back(a);
                    5'b10000: r[d] = a;
                    5'b10001: r[d] = ~a;
                    5'b10010: r[d] = -a;
                    5'b11000: r[d][15:0] = ref_mem[a[11:0]];
                    5'b11001: r[d][31:16] = ref_mem[a[11:0]];
                    default: ;
                endcase
            end else if (w[14:11] == 4'b0001) begin
                case (w[1:0])
                    2'd0: r[d] = a + b;
                    2'd1: r[d] = a - b;
                    2'd2: r[d] = a * b;
                    default: r[d] = $signed(a) >>> b[4:0];
                endcase
            end else if (w[14:11] == 4'b0010) begin
                case (w[1:0])
                    2'd0: r[d] = a & b;
                    2'd1: r[d] = a | b;
                    2'd2: r[d] = a ^ b;
                    default: r[d] = (a << b[4:0]) | (a >> (6'd32 - b[4:0]));
                endcase
            end else if (w[14:11] == 4'b0011 && !w[1]) begin
                ref_mem[b[11:0]] = w[0] ? a[31:16] : a[15:0];
            end else if (w[14:13] == 2'b01) begin
                r[d][8*w[12:11] +: 8] = w[7:0];
            end
        end
        $display("Reference model ran past its step limit without END");
        errors++;
    endfunction

    // Memory with random ready and response delay
    always @(posedge CLK) begin
        if (rst_n && mem_req_valid && mem_req_ready) begin
            if (mem_req.we) begin
                mem[mem_req.addr] = mem_req.wdata;
            end else begin
                rsp_data = mem[mem_req.addr];
                rsp_cnt  = 1 + {$random(seed)} % 4;
            end
        end
        #1;
        mem_rsp_valid = 1'b0;
        if (rsp_cnt > 0) begin
            rsp_cnt--;
            if (rsp_cnt == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp.rdata = rsp_data;
            end
        end
        mem_req_ready = ({$random(seed)} % 4) != 0;
        out_ready     = ({$random(seed)} % 3) != 0;
    end

    always @(posedge CLK) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output %h arrived after the last expected value", out_data);
                errors++;
            end else begin
                check_val("out_data", out_data, exp_q.pop_front());
            end
        end
    end

    initial begin
        int cyc;
        CLK           = 1'b0;
        rst_n         = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp       = '0;
        mem_rsp_valid = 1'b0;
        out_ready     = 1'b0;
        rsp_cnt       = 0;
        errors        = 0;
        seed          = 32'h7546;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = $random(seed);
        end
        build_program();
        ref_mem = mem;
        ref_exec();
        repeat (10) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        cyc   = 0;
        while (!halted && cyc < 20000) begin
            @(posedge CLK);
            cyc++;
        end
        if (!halted) begin
            $display("Timeout: the core did not halt within %0d cycles", cyc);
            errors++;
        end else begin
            for (int i = 0; i < 50; i++) begin
                @(posedge CLK);
                if (mem_req_valid || out_valid) begin
                    $display("The core issued a request or an output after halting");
                    errors++;
                end
            end
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected outputs never appeared", exp_q.size());
            errors++;
        end
        for (int i = 0; i < 4096; i++) begin
            check_val($sformatf("mem[%03h]", i), mem[i], ref_mem[i]);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+design
design/isa_pkg.sv
design/core_pkg.sv
design/alu.sv
design/reg_file.sv
design/instr_decoder.sv
design/core_sequencer.sv
design/core_top.sv
tests/core_tb_sva.sv
tests/core_tb.sv
